/* fm_mix_top.f */
+incdir+src
src/fm_mix_pkg.sv
src/mix_slot_counter.sv
src/mix_sequencer.sv
src/adpcm_sample_buf.sv
src/chan_cfg_regs.sv
src/single_acc.sv
src/slot_accum.sv
src/fm_mix_top.sv
verif/fm_mix_tb.sv

/* src/adpcm_sample_buf.sv */
`timescale 1ns/1ps
`include "fm_mix_config.svh"

module adpcm_sample_buf (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                valid,
    input  logic                pop,
    input  fm_mix_pkg::stereo_t sample,
    output logic                credit,
    output logic                empty,
    output fm_mix_pkg::stereo_t held
);
    import fm_mix_pkg::*;

    localparam int DEPTH = `ADPCM_DEPTH;
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    stereo_t       mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_pop;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty  = count == '0;
    assign do_pop = pop && !empty;   // Guard, sequencer only pops when filled

    // Sender credit guarantees a free entry on every valid
    always_ff @(posedge clk) begin
        if (valid) begin
            mem[wr_ptr] <= sample;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
            held   <= '0;                      // Silent until first pop
        end else begin
            credit <= do_pop;                  // Slot freed, hand credit back
            if (valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
                held   <= mem[rd_ptr];         // Stays put until next pop
            end
            case ({valid, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Both or neither
            endcase
        end
    end

endmodule

/* src/chan_cfg_regs.sv */
`timescale 1ns/1ps
`include "fm_mix_config.svh"

module chan_cfg_regs (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  cfg_we,
    input  logic [2:0]            cfg_ch,
    input  fm_mix_pkg::chan_cfg_t cfg,
    input  fm_mix_pkg::slot_t     slot,
    output fm_mix_pkg::chan_cfg_t cur_cfg
);
    import fm_mix_pkg::*;

    localparam int CHANNELS = `FM_SLOTS / 4;

    chan_cfg_t regs [CHANNELS];

    // Host writes ignore clk_en
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < CHANNELS; i++) begin
                regs[i] <= '0;                 // Pan off, alg 0
            end
        end else if (cfg_we && cfg_ch < 3'(CHANNELS)) begin
            regs[cfg_ch] <= cfg;
        end
    end

    // Read follows the slot, channels 6 and 7 do not exist
    assign cur_cfg = (slot.ch < 3'(CHANNELS)) ? regs[slot.ch] : '0;

endmodule

/* src/fm_mix_config.svh */
`ifndef FM_MIX_CONFIG_SVH
`define FM_MIX_CONFIG_SVH

// Frame layout, 4 operators x 6 channels
`define FM_SLOTS     24

// ADPCM FIFO entries, equal to the sender's starting credit
`define ADPCM_DEPTH  4

// Channels whose S1 slot carries ADPCM data instead of FM
`define ADPCMA_CH    2
`define ADPCMB_CH    5

`endif

/* src/fm_mix_pkg.sv */
package fm_mix_pkg;

    // One operator slot, frame runs op-major
    typedef struct packed {
        logic [1:0] op;   // 0..3 is S1..S4
        logic [2:0] ch;   // 0..5
    } slot_t;

    // Per-channel mixing setup
    typedef struct packed {
        logic [1:0] rl;   // [1] left on, [0] right on
        logic [2:0] alg;  // Operator connection
    } chan_cfg_t;

    // One stereo ADPCM sample
    typedef struct packed {
        logic signed [15:0] l;
        logic signed [15:0] r;
    } stereo_t;

    // Mixing sequencer
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } seq_state_e;

endpackage

/* src/fm_mix_top.sv */
`timescale 1ns/1ps

module fm_mix_top (
    input  logic                  clk,
    input  logic                  clk_en,
    input  logic                  arst_n,
    input  logic                  run,
    input  logic                  cfg_we,
    input  logic                  a_valid,
    input  logic                  b_valid,
    input  logic [2:0]            cfg_ch,
    input  fm_mix_pkg::chan_cfg_t cfg,
    input  fm_mix_pkg::stereo_t   a_sample,
    input  fm_mix_pkg::stereo_t   b_sample,
    input  logic signed [13:0]    op_result,
    output fm_mix_pkg::slot_t     slot,        // Tells the op pipeline where we are
    output logic                  a_credit,
    output logic                  b_credit,
    output logic signed [15:0]    left,
    output logic signed [15:0]    right,
    output logic [7:0]            underrun_cnt
);
    import fm_mix_pkg::*;

    logic      frame_start;
    logic      running;
    logic      pop_a;
    logic      pop_b;
    logic      a_empty;
    logic      b_empty;
    stereo_t   held_a;       // Last ADPCM-A sample, repeats on underrun
    stereo_t   held_b;
    chan_cfg_t cur_cfg;      // Setup of the channel in the current slot

    mix_slot_counter u_slot_counter (
        .clk         (clk),
        .clk_en      (clk_en),
        .arst_n      (arst_n),
        .running     (running),
        .slot        (slot),
        .frame_start (frame_start)
    );

    mix_sequencer u_sequencer (
        .clk          (clk),
        .clk_en       (clk_en),
        .arst_n       (arst_n),
        .run          (run),
        .frame_start  (frame_start),
        .slot         (slot),
        .a_empty      (a_empty),
        .b_empty      (b_empty),
        .running      (running),
        .pop_a        (pop_a),
        .pop_b        (pop_b),
        .underrun_cnt (underrun_cnt)
    );

    adpcm_sample_buf u_buf_a (
        .clk    (clk),
        .arst_n (arst_n),
        .valid  (a_valid),
        .pop    (pop_a),
        .sample (a_sample),
        .credit (a_credit),
        .empty  (a_empty),
        .held   (held_a)
    );

    adpcm_sample_buf u_buf_b (
        .clk    (clk),
        .arst_n (arst_n),
        .valid  (b_valid),
        .pop    (pop_b),
        .sample (b_sample),
        .credit (b_credit),
        .empty  (b_empty),
        .held   (held_b)
    );

    chan_cfg_regs u_cfg_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .cfg_we  (cfg_we),
        .cfg_ch  (cfg_ch),
        .cfg     (cfg),
        .slot    (slot),
        .cur_cfg (cur_cfg)
    );

    slot_accum u_accum (
        .clk         (clk),
        .clk_en      (clk_en),
        .arst_n      (arst_n),
        .frame_start (frame_start),
        .slot        (slot),
        .cur_cfg     (cur_cfg),
        .op_result   (op_result),
        .adpcm_a     (held_a),
        .adpcm_b     (held_b),
        .left        (left),
        .right       (right)
    );

endmodule

/* src/mix_sequencer.sv */
`timescale 1ns/1ps
`include "fm_mix_config.svh"

module mix_sequencer (
    input  logic              clk,
    input  logic              clk_en,
    input  logic              arst_n,
    input  logic              run,
    input  logic              frame_start,
    input  fm_mix_pkg::slot_t slot,
    input  logic              a_empty,
    input  logic              b_empty,
    output logic              running,
    output logic              pop_a,
    output logic              pop_b,
    output logic [7:0]        underrun_cnt
);
    import fm_mix_pkg::*;

    localparam int CHANNELS = `FM_SLOTS / 4;

    seq_state_e state;
    seq_state_e state_nxt;
    logic       last_slot;
    logic       fetch;

    assign last_slot = slot.op == 2'd3 && slot.ch == 3'(CHANNELS - 1);  // S4 of last channel
    assign running   = state != IDLE;
    assign fetch     = clk_en && state == RUN && frame_start;  // One fetch per frame
    assign pop_a     = fetch && !a_empty;
    assign pop_b     = fetch && !b_empty;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (run) begin
                    state_nxt = RUN;
                end
            end
            RUN: begin
                if (!run) begin
                    state_nxt = last_slot ? IDLE : DRAIN;  // Finish the open frame
                end
            end
            DRAIN: begin
                if (last_slot) begin
                    state_nxt = IDLE;                      // Frame finished
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= IDLE;
            underrun_cnt <= '0;
        end else if (clk_en) begin
            state <= state_nxt;
            // Starved frames counted up to 255
            if (fetch && (a_empty || b_empty) && underrun_cnt != 8'hff) begin
                underrun_cnt <= underrun_cnt + 8'd1;
            end
        end
    end

endmodule

/* src/mix_slot_counter.sv */
`timescale 1ns/1ps
`include "fm_mix_config.svh"

module mix_slot_counter (
    input  logic              clk,
    input  logic              clk_en,
    input  logic              arst_n,
    input  logic              running,
    output fm_mix_pkg::slot_t slot,
    output logic              frame_start
);

    localparam int CHANNELS = `FM_SLOTS / 4;

    logic last_ch;
    logic last_op;

    assign last_ch = slot.ch == 3'(CHANNELS - 1);
    assign last_op = slot.op == 2'd3;

    // Idle also parks on slot 0, so only flag it while mixing
    assign frame_start = running && slot == '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot <= '0;
        end else if (clk_en) begin
            if (!running) begin
                slot <= '0;                                    // Frame aligned restart
            end else if (last_ch) begin
                slot.ch <= '0;
                slot.op <= last_op ? 2'd0 : slot.op + 2'd1;    // S4 wraps to S1
            end else begin
                slot.ch <= slot.ch + 3'd1;                     // Channel steps first
            end
        end
    end

endmodule

/* src/single_acc.sv */
`timescale 1ns/1ps

module single_acc (
    input  logic               clk,
    input  logic               clk_en,
    input  logic               arst_n,
    input  logic               zero,
    input  logic               sum_en,
    input  logic signed [15:0] din,
    output logic signed [15:0] snd
);

    logic signed [17:0] acc;       // Two guard bits over the sample
    logic signed [17:0] din_ext;
    logic signed [15:0] acc_sat;

    assign din_ext = {{2{din[15]}}, din};

    always_comb begin
        if (acc > 18'sd32767) begin
            acc_sat = 16'h7fff;
        end else if (acc < -18'sd32768) begin
            acc_sat = 16'h8000;
        end else begin
            acc_sat = acc[15:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
            snd <= '0;
        end else if (clk_en) begin
            if (zero) begin
                acc <= sum_en ? din_ext : '0;  // New frame opens with this slot
                snd <= acc_sat;                // Previous frame goes out
            end else if (sum_en) begin
                acc <= acc + din_ext;
            end
        end
    end

endmodule

/* src/slot_accum.sv */
`timescale 1ns/1ps
`include "fm_mix_config.svh"

module slot_accum (
    input  logic                  clk,
    input  logic                  clk_en,
    input  logic                  arst_n,
    input  logic                  frame_start,
    input  fm_mix_pkg::slot_t     slot,
    input  fm_mix_pkg::chan_cfg_t cur_cfg,
    input  logic signed [13:0]    op_result,
    input  fm_mix_pkg::stereo_t   adpcm_a,
    input  fm_mix_pkg::stereo_t   adpcm_b,
    output logic signed [15:0]    left,
    output logic signed [15:0]    right
);

    logic               sum_en;
    logic               live;
    logic               en_l;
    logic               en_r;
    logic signed [15:0] op_ext;
    logic signed [15:0] in_l;
    logic signed [15:0] in_r;

    // ADPCM-A holds 12 bits, scale by 16 and clip anything wider
    function automatic logic signed [15:0] scale_a(input logic signed [15:0] s);
        logic pos_ovf;
        logic neg_ovf;
        pos_ovf = !s[15] && (|s[14:11]);
        neg_ovf = s[15] && !(&s[14:11]);
        if (neg_ovf) begin
            return 16'h8000;
        end
        if (pos_ovf) begin
            return 16'h7fff;
        end
        return {s[11:0], 4'd0};
    endfunction

    assign op_ext = {{2{op_result[13]}}, op_result};
    assign live   = frame_start || slot != '0;   // Parked slot 0 while idle adds nothing

    // Carrier decode per connection algorithm
    always_comb begin
        case (cur_cfg.alg)
            3'd4:       sum_en = slot.op == 2'd1 || slot.op == 2'd3;  // S2 and S4
            3'd5, 3'd6: sum_en = slot.op != 2'd0;                     // All but S1
            3'd7:       sum_en = 1'b1;
            default:    sum_en = slot.op == 2'd3;                     // S4 alone
        endcase
    end

    always_comb begin
        in_l = op_ext;
        in_r = op_ext;
        en_l = sum_en && cur_cfg.rl[1];
        en_r = sum_en && cur_cfg.rl[0];
        if (slot.op == 2'd0 && slot.ch == 3'(`ADPCMA_CH)) begin
            in_l = scale_a(adpcm_a.l);             // FM data dropped here
            in_r = scale_a(adpcm_a.r);
            en_l = 1'b1;
            en_r = 1'b1;
        end else if (slot.op == 2'd0 && slot.ch == 3'(`ADPCMB_CH)) begin
            in_l = $signed(adpcm_b.l) >>> 2;       // Bring 16 bits down near op level
            in_r = $signed(adpcm_b.r) >>> 2;
            en_l = 1'b1;
            en_r = 1'b1;
        end
    end

    single_acc u_left (
        .clk    (clk),
        .clk_en (clk_en),
        .arst_n (arst_n),
        .zero   (frame_start),
        .sum_en (en_l && live),
        .din    (in_l),
        .snd    (left)
    );

    single_acc u_right (
        .clk    (clk),
        .clk_en (clk_en),
        .arst_n (arst_n),
        .zero   (frame_start),
        .sum_en (en_r && live),
        .din    (in_r),
        .snd    (right)
    );

endmodule

/* verif/fm_mix_tb.sv */
`timescale 1ns/1ps
`include "fm_mix_config.svh"

module fm_mix_tb;
    import fm_mix_pkg::*;

    localparam int CLK_PERIOD    = 8;
    localparam int CHANNELS      = `FM_SLOTS / 4;
    localparam int RUN_FRAMES    = 40;
    localparam int STARVE_FRAMES = 270;
    localparam int REFILL_FRAMES = 6;
    // Plus the stopped frame and the idle tail
    localparam int TEST_FRAMES   = RUN_FRAMES + STARVE_FRAMES + REFILL_FRAMES + 2;
    localparam int WATCHDOG_NS   = (TEST_FRAMES + 4) * `FM_SLOTS * 2 * CLK_PERIOD;
    // Carrier mask per algorithm with bit n for operator S(n+1)
    localparam logic [31:0] CARRIERS = {4'b1111, 4'b1110, 4'b1110, 4'b1010,
                                        4'b1000, 4'b1000, 4'b1000, 4'b1000};

    logic               clk = 1'b0;
    logic               clk_en;
    logic               arst_n;
    logic               run;
    logic               cfg_we;
    logic               a_valid;
    logic               b_valid;
    logic [2:0]         cfg_ch;
    chan_cfg_t          cfg;
    stereo_t            a_sample;
    stereo_t            b_sample;
    logic signed [13:0] op_result;
    slot_t              slot;
    logic               a_credit;
    logic               b_credit;
    logic signed [15:0] left;
    logic signed [15:0] right;
    logic [7:0]         underrun_cnt;

    logic [31:0]        lfsr;
    logic               send_a;            // Sender enables
    logic               send_b;

    // Reference model state
    seq_state_e         m_state;
    int                 m_slot;
    int                 fs_cnt;            // Frame starts seen
    int                 m_under;
    logic signed [17:0] acc_l;
    logic signed [17:0] acc_r;
    int                 exp_l;
    int                 exp_r;
    stereo_t            held_a;
    stereo_t            held_b;
    stereo_t            q_a [$];           // Buffer contents
    stereo_t            q_b [$];
    int                 credits_a;
    int                 credits_b;
    int                 ret_a;
    int                 ret_b;
    int                 pops_a;
    int                 pops_b;
    logic               cred_due_a;        // Credit due after a pop
    logic               cred_due_b;
    chan_cfg_t          cfg_m [CHANNELS];

    fm_mix_top dut (.*);

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    // Half the ADPCM-A words stay inside 12 bits and the rest clip
    function automatic logic [15:0] a_word();
        logic [15:0] w;
        w = 16'(rand_bits(16));
        if (next_bit()) begin
            w = {{4{w[11]}}, w[11:0]};
        end
        return w;
    endfunction

    function automatic int clip_a(input logic signed [15:0] s);
        int v;
        v = s;
        if (v > 2047) begin
            return 32767;
        end
        if (v < -2048) begin
            return -32768;
        end
        return v * 16;
    endfunction

    function automatic int sat16(input logic signed [17:0] a);
        if (a > 32767) begin
            return 32767;
        end
        if (a < -32768) begin
            return -32768;
        end
        return a;
    endfunction

    task automatic report_failure(input string msg);
        $display("[FAIL] %0t %s", $time, msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = fs_cnt + n;
        while (fs_cnt < target) begin
            @(negedge clk);
        end
    endtask

    // Inputs change on the falling edge only
    always @(negedge clk) begin
        clk_en    = rand_bits(2) != 32'd0;     // About 3 of 4 cycles
        op_result = 14'(rand_bits(14));
        cfg_we    = rand_bits(3) == 32'd0;
        cfg_ch    = 3'(rand_bits(3));
        if (cfg_ch > 3'd5) begin
            cfg_ch = cfg_ch - 3'd4;            // Fold 6 and 7 onto real channels
        end
        cfg = 5'(rand_bits(5));
        a_valid = send_a && credits_a > 0 && next_bit();
        if (a_valid) begin
            credits_a--;                       // Spent on send
            a_sample.l = a_word();
            a_sample.r = a_word();
        end
        b_valid = send_b && credits_b > 0 && next_bit();
        if (b_valid) begin
            credits_b--;
            b_sample = rand_bits(32);
        end
    end

    always @(posedge clk) begin : ref_model
        int        op;
        int        ch;
        int        add_l;
        int        add_r;
        logic      was_running;
        logic      fs;
        logic      empty_a;
        logic      empty_b;
        chan_cfg_t c;
        if (!arst_n) begin
            m_state    = IDLE;
            m_slot     = 0;
            fs_cnt     = 0;
            m_under    = 0;
            acc_l      = '0;
            acc_r      = '0;
            exp_l      = 0;
            exp_r      = 0;
            held_a     = '0;
            held_b     = '0;
            q_a.delete();
            q_b.delete();
            credits_a  = `ADPCM_DEPTH;
            credits_b  = `ADPCM_DEPTH;
            ret_a      = 0;
            ret_b      = 0;
            pops_a     = 0;
            pops_b     = 0;
            cred_due_a = 1'b0;
            cred_due_b = 1'b0;
            for (int i = 0; i < CHANNELS; i++) begin
                cfg_m[i] = '0;
            end
        end else begin
            assert (int'(left) == exp_l && int'(right) == exp_r)
                else report_failure($sformatf("mix L %0d R %0d, expected L %0d R %0d",
                                              left, right, exp_l, exp_r));
            assert (a_credit == cred_due_a && b_credit == cred_due_b)
                else report_failure($sformatf("credit A %b B %b, expected A %b B %b",
                                              a_credit, b_credit, cred_due_a, cred_due_b));
            assert (int'(underrun_cnt) == m_under)
                else report_failure($sformatf("underrun_cnt %0d, expected %0d",
                                              underrun_cnt, m_under));
            cred_due_a = 1'b0;
            cred_due_b = 1'b0;
            if (a_credit) begin
                credits_a++;
                ret_a++;
            end
            if (b_credit) begin
                credits_b++;
                ret_b++;
            end
            assert (credits_a <= `ADPCM_DEPTH && credits_b <= `ADPCM_DEPTH)
                else report_failure("a sender got back more credits than it spent");
            if (clk_en) begin
                op = m_slot / CHANNELS;        // Op-major order
                ch = m_slot % CHANNELS;
                assert (slot.op == op && slot.ch == ch)
                    else report_failure($sformatf("slot op %0d ch %0d, expected op %0d ch %0d",
                                                  slot.op, slot.ch, op, ch));
                was_running = m_state != IDLE;
                fs          = was_running && m_slot == 0;
                c           = cfg_m[ch];
                add_l       = 0;
                add_r       = 0;
                if (CARRIERS[c.alg * 4 + op]) begin
                    if (c.rl[1]) begin
                        add_l = op_result;
                    end
                    if (c.rl[0]) begin
                        add_r = op_result;
                    end
                end
                if (op == 0 && ch == `ADPCMA_CH) begin
                    add_l = clip_a(held_a.l);  // No pan or alg gating
                    add_r = clip_a(held_a.r);
                end else if (op == 0 && ch == `ADPCMB_CH) begin
                    add_l = int'(held_b.l) >>> 2;
                    add_r = int'(held_b.r) >>> 2;
                end
                if (fs) begin
                    exp_l = sat16(acc_l);      // Last frame goes out
                    exp_r = sat16(acc_r);
                    acc_l = 18'(add_l);
                    acc_r = 18'(add_r);
                    fs_cnt++;
                end else if (m_slot != 0) begin
                    acc_l = 18'(acc_l + add_l);
                    acc_r = 18'(acc_r + add_r);
                end
                if (fs && m_state == RUN) begin
                    empty_a = q_a.size() == 0;
                    empty_b = q_b.size() == 0;
                    if (!empty_a) begin
                        held_a     = q_a.pop_front();
                        pops_a++;
                        cred_due_a = 1'b1;
                    end
                    if (!empty_b) begin
                        held_b     = q_b.pop_front();
                        pops_b++;
                        cred_due_b = 1'b1;
                    end
                    if ((empty_a || empty_b) && m_under < 255) begin
                        m_under++;
                    end
                end
                case (m_state)
                    IDLE:    m_state = run ? RUN : IDLE;
                    RUN:     m_state = run ? RUN : (m_slot == `FM_SLOTS - 1 ? IDLE : DRAIN);
                    default: m_state = (m_slot == `FM_SLOTS - 1) ? IDLE : DRAIN;
                endcase
                m_slot = was_running ? (m_slot + 1) % `FM_SLOTS : 0;
            end
            if (a_valid) begin
                q_a.push_back(a_sample);
            end
            if (b_valid) begin
                q_b.push_back(b_sample);
            end
            if (cfg_we) begin
                cfg_m[cfg_ch] = cfg;           // Host write on any cycle
            end
        end
    end

    credit_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        (a_credit || b_credit) |=> !(a_credit || b_credit))
        else report_failure("a credit stayed high for two cycles");

    slot_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !clk_en |=> $stable(slot))
        else report_failure("slot moved on a cycle without clk_en");

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the mixer did not finish its frames in time");
        $display("Finished with errors");
        $fatal(1);
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        lfsr      = 32'h54691b0c;
        arst_n    = 1'b0;
        run       = 1'b0;
        clk_en    = 1'b0;
        cfg_we    = 1'b0;
        cfg_ch    = '0;
        cfg       = '0;
        a_valid   = 1'b0;
        b_valid   = 1'b0;
        a_sample  = '0;
        b_sample  = '0;
        op_result = '0;
        send_a    = 1'b0;
        send_b    = 1'b0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        assert (left == 0 && right == 0 && a_credit == 0 && b_credit == 0
                && underrun_cnt == 0)
            else report_failure("outputs not cleared by reset");
        send_a = 1'b1;
        send_b = 1'b1;
        repeat (40) @(negedge clk);            // Buffers fill while idle
        run = 1'b1;
        wait_frames(RUN_FRAMES);
        send_a = 1'b0;                         // Starve A until the count saturates
        wait_frames(STARVE_FRAMES);
        assert (underrun_cnt == 8'hff)
            else report_failure($sformatf("underrun_cnt %0d, expected 255", underrun_cnt));
        send_a = 1'b1;
        wait_frames(REFILL_FRAMES);
        while (!(m_state == RUN && m_slot == 10)) begin
            @(negedge clk);
        end
        run = 1'b0;                            // Stop mid frame
        while (m_state != IDLE) begin
            @(negedge clk);
        end
        repeat (40) @(negedge clk);            // Outputs hold while idle
        send_a = 1'b0;
        send_b = 1'b0;
        repeat (4) @(negedge clk);
        assert (ret_a == pops_a && ret_b == pops_b)
            else report_failure($sformatf("credits back A %0d B %0d, pops A %0d B %0d",
                                          ret_a, ret_b, pops_a, pops_b));
        assert (credits_a + q_a.size() == `ADPCM_DEPTH && credits_b + q_b.size() == `ADPCM_DEPTH)
            else report_failure("credits and buffered samples do not add up to the depth");
        $display("Finished with no errors");
        $finish;
    end

endmodule
